/* vlog.f */
+incdir+test
source/io_pkg.sv
source/io_bus_fsm.sv
source/io_addr_decode.sv
source/gpio_regs.sv
source/irq_ctrl.sv
source/sys_timebase.sv
source/io_fabric_top.sv
test/tb_io_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I/O fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_io_fabric \
  -o sim_io_fabric > build.log 2>&1 &&
./obj_dir/sim_io_fabric > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

/* test/tb_axi_tasks.svh */
// AXI4-Lite driver tasks, random source and result check for the I/O fabric testbench
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    r      = {r[30:0], fb};
  end
  return r;
endfunction

task automatic fail_now(input string why);
  $display("%s", why);
  $display("*** TEST FAILED ***");
  $fatal(1);
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    fail_now($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
  end
endtask

// Second request offered while a response is held back
task automatic drive_pending();
  if (pend_kind == 1) begin
    araddr_i  = pend_addr;
    arvalid_i = 1'b1;
  end else if (pend_kind == 2) begin
    awaddr_i  = pend_addr;
    wdata_i   = pend_data;
    wstrb_i   = pend_strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
  end
endtask

// Returns one cycle after the accepting edge, at the drive point
task automatic wait_accept(input bit is_wr, output int waits);
  waits = 0;
  do begin
    @(negedge clk);
    waits++;
  end while (!(is_wr ? awready_o : arready_o));
  if (is_wr) check("wready", wready_o, 1);
  @(posedge clk);
  #1;
  if (is_wr) begin
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
  end else begin
    arvalid_i = 1'b0;
  end
endtask

task automatic finish_access(input bit is_wr, input addr_t a, input data_t d, input strb_t s,
                             input int bp_n, output data_t rd);
  int    lat;
  data_t held;
  lat = 0;
  do begin
    @(negedge clk);
    lat++;
    if (lat == 1) begin  // Request edge comes next
      if (is_wr) begin
        mdl_wr   = 1'b1;
        mdl_addr = a;
        mdl_data = d;
        mdl_strb = s;
      end else begin
        mdl_ack = (a == VEC_ADDR);
      end
    end
  end while (!(is_wr ? bvalid_o : rvalid_o) && lat < 8);
  check(is_wr ? "bvalid_latency" : "rvalid_latency", lat, 2);
  check("other_valid", is_wr ? rvalid_o : bvalid_o, 0);
  check(is_wr ? "bresp" : "rresp", is_wr ? bresp_o : rresp_o, 0);
  held = rdata_o;
  repeat (bp_n) begin
    @(posedge clk);
    #1;
    drive_pending();
    @(negedge clk);
    check(is_wr ? "bvalid_hold" : "rvalid_hold", is_wr ? bvalid_o : rvalid_o, 1);
    if (!is_wr) check("rdata_hold", rdata_o, held);
    check("awready_wait", awready_o, 0);
    check("wready_wait", wready_o, 0);
    check("arready_wait", arready_o, 0);
  end
  @(posedge clk);
  #1;
  bready_i = is_wr;
  rready_i = !is_wr;
  @(posedge clk);  // Handshake edge
  #1;
  bready_i = 1'b0;
  rready_i = 1'b0;
  rd = held;
endtask

task automatic axi_write(input addr_t a, input data_t d, input strb_t s, input int bp_n);
  int    w;
  data_t unused;
  awaddr_i  = a;
  wdata_i   = d;
  wstrb_i   = s;
  awvalid_i = 1'b1;
  wvalid_i  = 1'b1;
  wait_accept(1'b1, w);
  finish_access(1'b1, a, d, s, bp_n, unused);
endtask

task automatic axi_read(input addr_t a, input int bp_n, output data_t rd);
  int w;
  araddr_i  = a;
  arvalid_i = 1'b1;
  wait_accept(1'b0, w);
  finish_access(1'b0, a, '0, '0, bp_n, rd);
endtask

`endif

/* test/tb_io_fabric.sv */
`timescale 1ns/1ps
// Testbench for the I/O fabric: random bus traffic checked against a cycle model
module tb_io_fabric import io_pkg::*; ();

  localparam int    RST_HOLD    = 16;
  localparam int    TICK_PERIOD = 200;
  localparam int    CYCLE_LIMIT = 20000;
  localparam addr_t LED_ADDR    = 21'h10f100;
  localparam addr_t SW_ADDR     = 21'h10f104;
  localparam addr_t VEC_ADDR    = 21'h100020;
  localparam addr_t MASK_ADDR   = 21'h100024;
  localparam addr_t NOMAP_ADDR  = 21'h000100;

  logic        clk = 1'b0;
  logic        rst_lck;
  addr_t       awaddr_i;
  logic        awvalid_i;
  logic        awready_o;
  data_t       wdata_i;
  strb_t       wstrb_i;
  logic        wvalid_i;
  logic        wready_o;
  logic [1:0]  bresp_o;
  logic        bvalid_o;
  logic        bready_i;
  addr_t       araddr_i;
  logic        arvalid_i;
  logic        arready_o;
  data_t       rdata_o;
  logic [1:0]  rresp_o;
  logic        rvalid_o;
  logic        rready_i;
  logic [15:0] sw_i;
  logic [15:0] leds_o;
  logic [7:1]  irq_i;
  logic        intr_o;

  logic [31:0] lfsr_q = 32'h7979;
  int          cycles = 0;
  int          edge_k = -1;   // Edges since rst_lck release
  int          pend_kind = 0; // 0 none, 1 read, 2 write
  addr_t       pend_addr;
  data_t       pend_data;
  strb_t       pend_strb;

  // Model state and the hooks the bus tasks raise before a request edge
  logic        mdl_wr = 1'b0;
  logic        mdl_ack = 1'b0;
  addr_t       mdl_addr;
  data_t       mdl_data;
  strb_t       mdl_strb;
  logic [7:0]  m_pend = '0;
  logic [7:0]  m_mask = '1;
  logic [7:0]  m_prev = '0;
  logic        m_intr = 1'b0;
  logic [15:0] m_leds = '0;
  data_t       m_vec = '0;

  `include "tb_axi_tasks.svh"

  io_fabric_top #(
    .RST_HOLD    (RST_HOLD),
    .TICK_PERIOD (TICK_PERIOD)
  ) dut0 (
    .clk (clk), .rst_lck (rst_lck),
    .awaddr_i (awaddr_i), .awvalid_i (awvalid_i), .awready_o (awready_o),
    .wdata_i (wdata_i), .wstrb_i (wstrb_i), .wvalid_i (wvalid_i), .wready_o (wready_o),
    .bresp_o (bresp_o), .bvalid_o (bvalid_o), .bready_i (bready_i),
    .araddr_i (araddr_i), .arvalid_i (arvalid_i), .arready_o (arready_o),
    .rdata_o (rdata_o), .rresp_o (rresp_o), .rvalid_o (rvalid_o), .rready_i (rready_i),
    .sw_i (sw_i), .leds_o (leds_o), .irq_i (irq_i), .intr_o (intr_o)
  );

  always #4 clk = ~clk;

  function automatic bit in_gpio(input addr_t a);
    return a[20:3] == LED_ADDR[20:3];
  endfunction

  function automatic bit in_irq(input addr_t a);
    return a[20:3] == VEC_ADDR[20:3];
  endfunction

  // Timer pulse is seen on source 0 at these edges
  function automatic bit tick_at(input int k);
    return (k >= RST_HOLD + TICK_PERIOD) && ((k - RST_HOLD - TICK_PERIOD) % TICK_PERIOD == 0);
  endfunction

  function automatic int lowest(input logic [7:0] v);
    for (int i = 0; i < 8; i++) begin
      if (v[i]) return i;
    end
    return -1;
  endfunction

  always @(posedge clk) begin : model
    logic [7:0] src;
    logic [7:0] rise;
    logic [7:0] elig;
    logic [7:0] clr;
    int         p;
    edge_k = rst_lck ? edge_k + 1 : -1;
    src    = {irq_i, tick_at(edge_k)};
    if (edge_k < RST_HOLD) begin  // Internal reset still low at this edge
      m_pend = '0;
      m_mask = '1;
      m_intr = 1'b0;
      m_leds = '0;
    end else begin
      rise = src & ~m_prev;
      elig = m_pend & ~m_mask;
      clr  = '0;
      if (mdl_ack) begin
        p = lowest(elig);
        m_vec = (p < 0) ? 32'd0 : 32'd8 + p;
        if (p >= 0) clr[p] = 1'b1;
      end
      if (mdl_wr && in_gpio(mdl_addr) && !mdl_addr[2]) begin
        if (mdl_strb[0]) m_leds[7:0] = mdl_data[7:0];
        if (mdl_strb[1]) m_leds[15:8] = mdl_data[15:8];
      end
      if (mdl_wr && in_irq(mdl_addr) && mdl_addr[2] && mdl_strb[0]) m_mask = mdl_data[7:0];
      m_pend = (m_pend & ~clr) | rise;
      m_intr = |elig;
    end
    m_prev  = src;
    mdl_wr  = 1'b0;
    mdl_ack = 1'b0;
  end

  always @(negedge clk) begin
    if (edge_k >= 0) begin
      check("intr_o", intr_o, m_intr);
      check("leds_o", leds_o, m_leds);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) fail_now("Timeout: the run did not finish in time");
  end

  initial begin : stimulus
    data_t r;
    data_t rd;
    addr_t a;
    int    w;
    int    n;
    {awaddr_i, awvalid_i, wdata_i, wstrb_i, wvalid_i, bready_i} = '0;
    {araddr_i, arvalid_i, rready_i, sw_i, irq_i} = '0;
    rst_lck = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    araddr_i  = NOMAP_ADDR;  // Offered during the reset stretch
    arvalid_i = 1'b1;
    rst_lck   = 1'b1;
    for (int k = 0; k < RST_HOLD; k++) begin
      @(negedge clk);
      check("arready_rst", arready_o, 0);
      check("awready_rst", awready_o, 0);
      check("wready_rst", wready_o, 0);
      check("bvalid_rst", bvalid_o, 0);
      check("rvalid_rst", rvalid_o, 0);
    end
    wait_accept(1'b0, w);
    check("reset_hold_end", w, 1);
    finish_access(1'b0, NOMAP_ADDR, '0, '0, 0, rd);
    check("rdata_default", rd, 32'h0000_ffff);

    for (int i = 0; i < 40; i++) begin
      r = lfsr_bits(32);
      axi_write(LED_ADDR, r, strb_t'(lfsr_bits(4)), 0);
      axi_read(LED_ADDR, 0, rd);
      check("rdata_led", rd, {16'h0, m_leds});
      r = lfsr_bits(16);
      sw_i = r[15:0];
      repeat (3) @(posedge clk);
      #1;
      axi_read(SW_ADDR, 0, rd);
      check("rdata_sw", rd, {16'h0, sw_i});
    end

    for (int i = 0; i < 20; i++) begin
      a = addr_t'(lfsr_bits(21));
      if (in_gpio(a) || in_irq(a)) a = a ^ 21'h000400;
      axi_read(a, 0, rd);
      check("rdata_default", rd, 32'h0000_ffff);
      axi_write(a, lfsr_bits(32), strb_t'(lfsr_bits(4)), 0);
      axi_read(LED_ADDR, 0, rd);
      check("rdata_led", rd, {16'h0, m_leds});
      axi_read(MASK_ADDR, 0, rd);
      check("rdata_mask", rd, {24'h0, m_mask});
    end

    for (int i = 0; i < 10; i++) begin
      axi_write(MASK_ADDR, lfsr_bits(8), 4'hf, 0);
      r = lfsr_bits(7);
      irq_i = r[6:0];
      @(posedge clk);
      #1;
      irq_i = '0;
      repeat (2) @(posedge clk);
      #1;
      n = 0;
      do begin
        axi_read(VEC_ADDR, 0, rd);
        check("rdata_vector", rd, m_vec);
        n++;
      end while (rd != 0 && n < 12);
      if (rd != 0) fail_now("Vector reads never ran out of eligible sources");
    end

    axi_write(MASK_ADDR, 32'h0000_00fe, 4'h1, 0);  // Only the timer unmasked
    for (int t = 0; t < 2; t++) begin
      do begin
        @(posedge clk);
        #1;
      end while (!tick_at(edge_k));
      axi_read(VEC_ADDR, 0, rd);
      check("rdata_timer_vector", rd, 32'd8);
      axi_read(VEC_ADDR, 0, rd);
      check("rdata_before_tick", rd, 32'd0);
    end

    for (int i = 0; i < 6; i++) begin
      pend_kind = 1;
      pend_addr = LED_ADDR;
      axi_write(LED_ADDR, lfsr_bits(32), 4'hf, int'(lfsr_bits(3)));
      pend_kind = 0;
      axi_read(LED_ADDR, 0, rd);
      check("rdata_led", rd, {16'h0, m_leds});
      pend_kind = 2;
      pend_addr = MASK_ADDR;
      pend_data = lfsr_bits(32);
      pend_strb = 4'h1;
      axi_read(LED_ADDR, int'(lfsr_bits(3)), rd);
      check("rdata_led", rd, {16'h0, m_leds});
      pend_kind = 0;
      axi_write(MASK_ADDR, pend_data, pend_strb, 0);
    end

    repeat (4) @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* source/io_fabric_top.sv */
`timescale 1ns/1ps
// I/O fabric top: AXI4-Lite slave, address switch, GPIO, interrupt controller and timebase
module io_fabric_top import io_pkg::*; #(
  parameter int    RST_HOLD    = 16,
  parameter int    TICK_PERIOD = 200,
  parameter addr_t GPIO_BASE   = io_pkg::GPIO_BASE,
  parameter addr_t GPIO_MASK   = io_pkg::GPIO_MASK,
  parameter addr_t IRQ_BASE    = io_pkg::IRQ_BASE,
  parameter addr_t IRQ_MASK    = io_pkg::IRQ_MASK
) (
  input  logic             clk,
  input  logic             rst_lck,
  input  addr_t            awaddr_i,
  input  logic             awvalid_i,
  output logic             awready_o,
  input  data_t            wdata_i,
  input  strb_t            wstrb_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  output logic [1:0]       bresp_o,
  output logic             bvalid_o,
  input  logic             bready_i,
  input  addr_t            araddr_i,
  input  logic             arvalid_i,
  output logic             arready_o,
  output data_t            rdata_o,
  output logic [1:0]       rresp_o,
  output logic             rvalid_o,
  input  logic             rready_i,
  input  logic [REG_W-1:0] sw_i,
  output logic [REG_W-1:0] leds_o,
  input  logic [IRQ_N-1:1] irq_i,
  output logic             intr_o
);

  logic    sys_rst_n;
  logic    timer_tick;
  io_req_t req;
  data_t   bus_rdata;
  logic    gpio_sel;
  logic    irq_sel;
  data_t   gpio_rdata;
  data_t   irq_rdata;

  sys_timebase #(
    .RST_HOLD    (RST_HOLD),
    .TICK_PERIOD (TICK_PERIOD)
  ) u_timebase (
    .clk          (clk),
    .rst_lck      (rst_lck),
    .sys_rst_n_o  (sys_rst_n),
    .timer_tick_o (timer_tick)
  );

  io_bus_fsm u_bus (
    .clk         (clk),
    .sys_rst_n_i (sys_rst_n),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .req_o       (req),
    .rdata_i     (bus_rdata)
  );

  io_addr_decode #(
    .GPIO_BASE (GPIO_BASE),
    .GPIO_MASK (GPIO_MASK),
    .IRQ_BASE  (IRQ_BASE),
    .IRQ_MASK  (IRQ_MASK)
  ) u_decode (
    .req_i        (req),
    .gpio_sel_o   (gpio_sel),
    .irq_sel_o    (irq_sel),
    .gpio_rdata_i (gpio_rdata),
    .irq_rdata_i  (irq_rdata),
    .rdata_o      (bus_rdata)
  );

  gpio_regs u_gpio (
    .clk         (clk),
    .sys_rst_n_i (sys_rst_n),
    .req_i       (req),
    .sel_i       (gpio_sel),
    .rdata_o     (gpio_rdata),
    .leds_o      (leds_o),
    .sw_i        (sw_i)
  );

  // Timer owns source 0, the rest come from outside
  irq_ctrl u_irq (
    .clk         (clk),
    .sys_rst_n_i (sys_rst_n),
    .req_i       (req),
    .sel_i       (irq_sel),
    .rdata_o     (irq_rdata),
    .irq_src_i   ({irq_i, timer_tick}),
    .intr_o      (intr_o)
  );

endmodule

/* source/sys_timebase.sv */
`timescale 1ns/1ps
// Reset stretcher after rst_lck release, plus the periodic timer tick
module sys_timebase #(
  parameter int RST_HOLD    = 16,
  parameter int TICK_PERIOD = 200
) (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_n_o,
  output logic timer_tick_o
);

  localparam int RW = $clog2(RST_HOLD + 1);
  localparam int TW = $clog2(TICK_PERIOD);

  logic [RW-1:0] hold_q;
  logic [TW-1:0] tick_cnt_q;
  logic          tick_wrap;

  // Down-counter reloads while rst_lck is low
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      hold_q      <= RW'(RST_HOLD);
      sys_rst_n_o <= 1'b0;
    end else begin
      if (hold_q != '0) hold_q <= hold_q - 1'b1;
      sys_rst_n_o <= (hold_q <= RW'(1));  // Low for RST_HOLD cycles after release
    end
  end

  assign tick_wrap = (tick_cnt_q == TW'(TICK_PERIOD - 1));

  // Free-running period counter, first tick TICK_PERIOD cycles after release
  always_ff @(posedge clk) begin
    if (!sys_rst_n_o) begin
      tick_cnt_q   <= '0;
      timer_tick_o <= 1'b0;
    end else begin
      timer_tick_o <= tick_wrap;
      tick_cnt_q   <= tick_wrap ? '0 : tick_cnt_q + 1'b1;
    end
  end

endmodule

/* source/irq_ctrl.sv */
`timescale 1ns/1ps
// Simple interrupt controller: edge-latched pending bits, mask and acknowledge vector
module irq_ctrl import io_pkg::*; (
  input  logic             clk,
  input  logic             sys_rst_n_i,
  input  io_req_t          req_i,
  input  logic             sel_i,
  output data_t            rdata_o,
  input  logic [IRQ_N-1:0] irq_src_i,
  output logic             intr_o
);

  localparam int IDX_W = $clog2(IRQ_N);

  logic [IRQ_N-1:0] src_q;
  logic [IRQ_N-1:0] pend_q;
  logic [IRQ_N-1:0] mask_q;   // 1 = masked
  logic [IRQ_N-1:0] rise;
  logic [IRQ_N-1:0] elig;
  logic [IRQ_N-1:0] clr_vec;
  logic [IDX_W-1:0] pick;
  logic             found;
  logic             ack_rd;
  logic             mask_we;

  assign rise = irq_src_i & ~src_q;
  assign elig = pend_q & ~mask_q;

  // Lowest-numbered eligible source wins
  always_comb begin
    found = 1'b0;
    pick  = '0;
    for (int i = IRQ_N - 1; i >= 0; i--) begin
      if (elig[i]) begin
        found = 1'b1;
        pick  = IDX_W'(i);
      end
    end
  end

  assign ack_rd  = req_i.valid && sel_i && !req_i.write && !req_i.addr[2];
  assign mask_we = req_i.valid && sel_i && req_i.write && req_i.addr[2] && req_i.wstrb[0];
  assign clr_vec = (ack_rd && found) ? (IRQ_N'(1) << pick) : '0;

  always_comb begin
    if (req_i.addr[2]) begin
      rdata_o = data_t'(mask_q);
    end else if (found) begin
      rdata_o = IACK_VEC_BASE + data_t'(pick);
    end else begin
      rdata_o = '0;  // Nothing to acknowledge
    end
  end

  always_ff @(posedge clk) begin
    src_q <= irq_src_i;
  end

  always_ff @(posedge clk) begin
    if (!sys_rst_n_i) begin
      pend_q <= '0;
      mask_q <= '1;
      intr_o <= 1'b0;
    end else begin
      pend_q <= (pend_q & ~clr_vec) | rise;  // A new edge beats the clear
      if (mask_we) mask_q <= req_i.wdata[IRQ_N-1:0];
      intr_o <= |elig;
    end
  end

  // Masked sources stay pending through any acknowledge
  a_masked_stay: assert property (@(posedge clk) disable iff (!sys_rst_n_i)
    (|(pend_q & mask_q)) |=>
      ((pend_q & $past(pend_q & mask_q)) == $past(pend_q & mask_q)));

endmodule

/* source/gpio_regs.sv */
`timescale 1ns/1ps
// LED output register and synchronized switch inputs
module gpio_regs import io_pkg::*; (
  input  logic             clk,
  input  logic             sys_rst_n_i,
  input  io_req_t          req_i,
  input  logic             sel_i,
  output data_t            rdata_o,
  output logic [REG_W-1:0] leds_o,
  input  logic [REG_W-1:0] sw_i
);

  logic [REG_W-1:0] leds_q;
  logic [REG_W-1:0] sw_meta_q;
  logic [REG_W-1:0] sw_sync_q;
  logic             led_we;

  // Word 0 is the LEDs, word 1 the switches
  assign led_we = req_i.valid && sel_i && req_i.write && !req_i.addr[2];

  always_ff @(posedge clk) begin
    if (!sys_rst_n_i) begin
      leds_q <= '0;
    end else if (led_we) begin
      for (int b = 0; b < REG_W / 8; b++) begin
        if (req_i.wstrb[b]) leds_q[b*8 +: 8] <= req_i.wdata[b*8 +: 8];
      end
    end
  end

  // Two-flop synchronizer for the board switches
  always_ff @(posedge clk) begin
    sw_meta_q <= sw_i;
    sw_sync_q <= sw_meta_q;
  end

  assign rdata_o = data_t'(req_i.addr[2] ? sw_sync_q : leds_q);  // Upper half reads zero
  assign leds_o  = leds_q;

endmodule

/* source/io_addr_decode.sv */
`timescale 1ns/1ps
// Mask-and-match address switch with a default target and the read data mux
module io_addr_decode import io_pkg::*; #(
  parameter addr_t GPIO_BASE = io_pkg::GPIO_BASE,
  parameter addr_t GPIO_MASK = io_pkg::GPIO_MASK,
  parameter addr_t IRQ_BASE  = io_pkg::IRQ_BASE,
  parameter addr_t IRQ_MASK  = io_pkg::IRQ_MASK
) (
  input  io_req_t req_i,
  output logic    gpio_sel_o,
  output logic    irq_sel_o,
  input  data_t   gpio_rdata_i,
  input  data_t   irq_rdata_i,
  output data_t   rdata_o
);

  tgt_sel_t tgt;

  always_comb begin
    if ((req_i.addr & GPIO_MASK) == GPIO_BASE) begin
      tgt = TGT_GPIO;
    end else if ((req_i.addr & IRQ_MASK) == IRQ_BASE) begin
      tgt = TGT_IRQ;
    end else begin
      tgt = TGT_DEFAULT;  // Anything unmapped
    end
  end

  assign gpio_sel_o = req_i.valid && (tgt == TGT_GPIO);
  assign irq_sel_o  = req_i.valid && (tgt == TGT_IRQ);

  // Default target ignores writes and reads back a fixed pattern
  always_comb begin
    case (tgt)
      TGT_GPIO: rdata_o = gpio_rdata_i;
      TGT_IRQ:  rdata_o = irq_rdata_i;
      default:  rdata_o = DEFAULT_RDATA;
    endcase
  end

  // Disjoint regions guarantee at most one select for any address
  initial begin
    a_no_overlap: assert (((GPIO_BASE ^ IRQ_BASE) & GPIO_MASK & IRQ_MASK) != '0)
      else $error("io_addr_decode: GPIO and IRQ regions overlap");
  end

endmodule

/* source/io_bus_fsm.sv */
`timescale 1ns/1ps
// AXI4-Lite slave front end turning one access at a time into a single-cycle request
module io_bus_fsm import io_pkg::*; (
  input  logic       clk,
  input  logic       sys_rst_n_i,
  input  addr_t      awaddr_i,
  input  logic       awvalid_i,
  output logic       awready_o,
  input  data_t      wdata_i,
  input  strb_t      wstrb_i,
  input  logic       wvalid_i,
  output logic       wready_o,
  output logic [1:0] bresp_o,
  output logic       bvalid_o,
  input  logic       bready_i,
  input  addr_t      araddr_i,
  input  logic       arvalid_i,
  output logic       arready_o,
  output data_t      rdata_o,
  output logic [1:0] rresp_o,
  output logic       rvalid_o,
  input  logic       rready_i,
  output io_req_t    req_o,
  input  data_t      rdata_i
);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  bus_state_t state_q;
  logic       write_q;
  addr_t      addr_q;
  data_t      wdata_q;
  strb_t      wstrb_q;
  data_t      rdata_q;
  logic       wr_acc;
  logic       rd_acc;
  logic       resp_done;

  // Writes need both channels and win over a pending read
  assign wr_acc = sys_rst_n_i && (state_q == ST_IDLE) && awvalid_i && wvalid_i;
  assign rd_acc = sys_rst_n_i && (state_q == ST_IDLE) && arvalid_i && !(awvalid_i || wvalid_i);

  assign awready_o = wr_acc;
  assign wready_o  = wr_acc;
  assign arready_o = rd_acc;

  assign bvalid_o  = (state_q == ST_RESP) && write_q;
  assign rvalid_o  = (state_q == ST_RESP) && !write_q;
  assign bresp_o   = RESP_OKAY;
  assign rresp_o   = RESP_OKAY;
  assign rdata_o   = rdata_q;
  assign resp_done = (bvalid_o && bready_i) || (rvalid_o && rready_i);

  always_comb begin
    req_o.valid = (state_q == ST_ACCESS);
    req_o.write = write_q;
    req_o.addr  = addr_q;
    req_o.wdata = wdata_q;
    req_o.wstrb = wstrb_q;
  end

  always_ff @(posedge clk) begin
    if (!sys_rst_n_i) begin
      state_q  <= ST_IDLE;
      write_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_acc) begin
            write_q <= 1'b1;
            state_q <= ST_ACCESS;
          end else if (rd_acc) begin
            write_q <= 1'b0;
            state_q <= ST_ACCESS;
          end
        end
        ST_ACCESS: state_q <= ST_RESP;
        ST_RESP:   if (resp_done) state_q <= ST_IDLE;  // Hold until the master takes it
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Captured address and data, plus the read result latched on leaving ST_ACCESS
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      addr_q  <= awaddr_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end else if (rd_acc) begin
      addr_q  <= araddr_i;
      wstrb_q <= '0;
    end
    if ((state_q == ST_ACCESS) && !write_q) rdata_q <= rdata_i;
  end

  // Accepted write issues its request next cycle and answers on B one cycle later
  a_wr_latency: assert property (@(posedge clk) disable iff (!sys_rst_n_i)
    awready_o |=> (req_o.valid && req_o.write) ##1 (bvalid_o && !rvalid_o));

  // Same two-cycle path for reads, answered on R
  a_rd_latency: assert property (@(posedge clk) disable iff (!sys_rst_n_i)
    arready_o |=> (req_o.valid && !req_o.write) ##1 (rvalid_o && !bvalid_o));

  // A stalled read response keeps its data and blocks new addresses
  a_resp_hold: assert property (@(posedge clk) disable iff (!sys_rst_n_i)
    (rvalid_o && !rready_i) |=> rvalid_o && $stable(rdata_o) && !arready_o && !awready_o);

endmodule

/* source/io_pkg.sv */
// I/O fabric shared definitions: bus widths, request struct, enums and address map
package io_pkg;

  localparam int ADDR_W = 21;  // Bit 20 flags I/O space, 19:0 byte address
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int REG_W  = 16;  // Peripheral registers sit in the low half-word
  localparam int IRQ_N  = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Single-cycle request from the bus FSM to the targets
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } io_req_t;

  typedef enum logic [1:0] {
    TGT_GPIO,
    TGT_IRQ,
    TGT_DEFAULT
  } tgt_sel_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESP
  } bus_state_t;

  localparam data_t IACK_VEC_BASE = 32'd8;          // Vector = base + source number
  localparam data_t DEFAULT_RDATA = 32'h0000_ffff;  // Unmapped reads

  // Region match is (addr & MASK) == BASE
  localparam addr_t GPIO_BASE = 21'h10f100;  // io 0xf100 - 0xf107
  localparam addr_t GPIO_MASK = 21'h1ffff8;
  localparam addr_t IRQ_BASE  = 21'h100020;  // io 0x0020 - 0x0027
  localparam addr_t IRQ_MASK  = 21'h1ffff8;

endpackage
